/* verilog/tcdm_fifo_pkg.sv */
// field types, packed word widths and queue sizing
// shared by both queues of the TCDM decoupling FIFO

package tcdm_fifo_pkg;

  // request fields
  localparam int unsigned ADDR_W = 32;         // word address
  localparam int unsigned DATA_W = 32;         // read and write data
  localparam int unsigned BE_W   = DATA_W / 8; // one enable per byte lane

  // packed request: addr, wdata, be, wen (msb to lsb)
  localparam int unsigned REQ_W = ADDR_W + DATA_W + BE_W + 1;

  // response word carries read data only
  localparam int unsigned RSP_W = DATA_W;

  // queue sizing, power of two
  localparam int unsigned FIFO_DEPTH = 8;

  // one free slot left counts as almost full
  localparam int unsigned ALMOST_FULL_LVL = FIFO_DEPTH - 1;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;
  typedef logic [REQ_W-1:0]  req_word_t;

endpackage

/* verilog/sync_fifo.sv */
// flip-flop FIFO with valid/ready on both sides
// no fall-through; flags for empty and almost full

module sync_fifo
  import tcdm_fifo_pkg::*;
#(
  parameter int unsigned WIDTH = RSP_W,
  parameter int unsigned DEPTH = FIFO_DEPTH // power of two, at least 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,      // synchronous flush

  input  logic             push_valid_i,
  input  logic [WIDTH-1:0] push_data_i,
  output logic             push_ready_o, // not full

  output logic             pop_valid_o,  // not empty
  output logic [WIDTH-1:0] pop_data_o,
  input  logic             pop_ready_i,

  output logic             empty_o,
  output logic             almost_full_o
);

  localparam int unsigned PTR_W  = $clog2(DEPTH);
  localparam int unsigned CNT_W  = $clog2(DEPTH + 1);
  // keep the same distance from full as the package level does at FIFO_DEPTH
  localparam int unsigned AF_LVL = DEPTH - (FIFO_DEPTH - ALMOST_FULL_LVL);

  logic [WIDTH-1:0] mem_q [DEPTH]; // storage, no reset needed
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;       // occupancy

  logic push_fire;
  logic pop_fire;

  assign push_ready_o  = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o   = (count_q != '0);
  assign pop_data_o    = mem_q[rd_ptr_q];  // head always visible
  assign empty_o       = (count_q == '0);
  assign almost_full_o = (count_q >= CNT_W'(AF_LVL)); // includes full

  assign push_fire = push_valid_i & push_ready_o;
  assign pop_fire  = pop_valid_o & pop_ready_i;

  // pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_fire) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (pop_fire)  rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q; // both or neither, level unchanged
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // occupancy must stay in range over any push/pop sequence
  a_count_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    count_q <= CNT_W'(DEPTH)
  ) else $error("sync_fifo: occupancy above DEPTH");

  // an empty queue has read pointer on write pointer, a pop past it is an underflow
  a_no_pop_when_empty : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    empty_o |-> (rd_ptr_q == wr_ptr_q)
  ) else $error("sync_fifo: read pointer ran past write pointer");

endmodule

/* verilog/req_queue.sv */
// request queue: packs target requests into a FIFO and replays them
// on the memory side, held back while the response side has no room

module req_queue
  import tcdm_fifo_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,

  // target side (core)
  input  logic  req_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  be_t   be_i,
  input  logic  wen_i,       // high for a read
  output logic  gnt_o,

  // initiator side (memory)
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o,
  output be_t   mem_be_o,
  output logic  mem_wen_o,
  input  logic  mem_gnt_i,

  input  logic  resp_room_i, // response queue can absorb one more answer
  output logic  empty_o
);

  req_word_t push_word;
  req_word_t pop_word;
  logic      head_valid;
  logic      head_ready;

  assign push_word = {addr_i, wdata_i, be_i, wen_i}; // addr on top, wen at lsb

  // unpack head entry straight onto the memory port
  assign {mem_addr_o, mem_wdata_o, mem_be_o, mem_wen_o} = pop_word;

  assign mem_req_o  = head_valid & resp_room_i; // throttle on response room
  assign head_ready = mem_gnt_i & resp_room_i;  // pops only on req & gnt

  sync_fifo #(
    .WIDTH ( REQ_W      ),
    .DEPTH ( FIFO_DEPTH )
  ) i_req_fifo (
    .clk_i         ( clk_i      ),
    .rst_ni        ( rst_ni     ),
    .clear_i       ( clear_i    ),
    .push_valid_i  ( req_i      ),
    .push_data_i   ( push_word  ),
    .push_ready_o  ( gnt_o      ), // grant while not full
    .pop_valid_o   ( head_valid ),
    .pop_data_o    ( pop_word   ),
    .pop_ready_i   ( head_ready ),
    .empty_o       ( empty_o    ),
    .almost_full_o (            )
  );

  // memory must only grant a pending request
  a_gnt_needs_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !mem_req_o |-> !mem_gnt_i
  ) else $error("req_queue: mem_gnt_i without mem_req_o");

endmodule

/* verilog/resp_queue.sv */
// response queue: one-entry capture buffer in front of the response FIFO,
// plus the room signal that lets the request side issue

module resp_queue
  import tcdm_fifo_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,

  // initiator side (memory)
  input  logic  mem_r_valid_i,
  input  data_t mem_r_data_i,
  output logic  mem_r_ready_o,

  // target side (core)
  output logic  r_valid_o,
  output data_t r_data_o,
  input  logic  r_ready_i,

  output logic  resp_room_o,  // to req_queue
  output logic  empty_o
);

  logic  capt_valid_q;  // capture buffer occupied
  data_t capt_data_q;   // payload, no reset

  logic  push_valid;
  data_t push_data;
  logic  push_ready;
  logic  fifo_empty;
  logic  fifo_afull;
  logic  capt_load;

  // held entry is older, so it goes first; fresh one takes its place
  assign push_valid = capt_valid_q | mem_r_valid_i;
  assign push_data  = capt_valid_q ? capt_data_q : mem_r_data_i;

  // capture a fresh response that cannot go into the FIFO this cycle
  always_comb begin
    if (capt_valid_q) begin
      capt_load = mem_r_valid_i & push_ready; // held drains, fresh replaces it
    end else begin
      capt_load = mem_r_valid_i & ~push_ready;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      capt_valid_q <= 1'b0;
    end else if (clear_i) begin
      capt_valid_q <= 1'b0;
    end else if (capt_valid_q) begin
      if (push_ready) capt_valid_q <= mem_r_valid_i; // refilled or empty
    end else begin
      capt_valid_q <= capt_load;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capt_load) begin
      capt_data_q <= mem_r_data_i;
    end
  end

  assign mem_r_ready_o = push_ready; // not full

  // hold off new requests when full, or when the last slot is about
  // to be taken by an arriving answer that the core will not drain
  assign resp_room_o = push_ready & ~(fifo_afull & mem_r_valid_i & ~r_ready_i);

  assign empty_o = fifo_empty & ~capt_valid_q;

  sync_fifo #(
    .WIDTH ( RSP_W      ),
    .DEPTH ( FIFO_DEPTH )
  ) i_rsp_fifo (
    .clk_i         ( clk_i      ),
    .rst_ni        ( rst_ni     ),
    .clear_i       ( clear_i    ),
    .push_valid_i  ( push_valid ),
    .push_data_i   ( push_data  ),
    .push_ready_o  ( push_ready ),
    .pop_valid_o   ( r_valid_o  ),
    .pop_data_o    ( r_data_o   ),
    .pop_ready_i   ( r_ready_i  ),
    .empty_o       ( fifo_empty ),
    .almost_full_o ( fifo_afull )
  );

  // a second answer while one is stuck in the buffer would be lost
  a_no_capture_overrun : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    capt_valid_q && !push_ready |-> !mem_r_valid_i
  ) else $error("resp_queue: response dropped, capture buffer busy");

endmodule

/* verilog/tcdm_fifo.sv */
// top level of the TCDM decoupling FIFO
// request and response queues between core port and memory port

module tcdm_fifo
  import tcdm_fifo_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,        // empties both queues in one cycle

  // target side (core)
  input  logic  req_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  be_t   be_i,
  input  logic  wen_i,          // high for a read
  output logic  gnt_o,
  output logic  r_valid_o,
  output data_t r_data_o,
  input  logic  r_ready_i,

  // initiator side (memory)
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o,
  output be_t   mem_be_o,
  output logic  mem_wen_o,
  input  logic  mem_gnt_i,
  input  logic  mem_r_valid_i,
  input  data_t mem_r_data_i,
  output logic  mem_r_ready_o,

  output logic  empty_o         // nothing queued in either direction
);

  logic resp_room;
  logic req_empty;
  logic rsp_empty;

  req_queue i_req_queue (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .req_i       ( req_i       ),
    .addr_i      ( addr_i      ),
    .wdata_i     ( wdata_i     ),
    .be_i        ( be_i        ),
    .wen_i       ( wen_i       ),
    .gnt_o       ( gnt_o       ),
    .mem_req_o   ( mem_req_o   ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_wdata_o ( mem_wdata_o ),
    .mem_be_o    ( mem_be_o    ),
    .mem_wen_o   ( mem_wen_o   ),
    .mem_gnt_i   ( mem_gnt_i   ),
    .resp_room_i ( resp_room   ),
    .empty_o     ( req_empty   )
  );

  resp_queue i_resp_queue (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .mem_r_valid_i ( mem_r_valid_i ),
    .mem_r_data_i  ( mem_r_data_i  ),
    .mem_r_ready_o ( mem_r_ready_o ),
    .r_valid_o     ( r_valid_o     ),
    .r_data_o      ( r_data_o      ),
    .r_ready_i     ( r_ready_i     ),
    .resp_room_o   ( resp_room     ),
    .empty_o       ( rsp_empty     )
  );

  assign empty_o = req_empty & rsp_empty;

endmodule

/* tb/tcdm_mem_model.sv */
// memory behind the TCDM initiator port
// random grant, byte-enabled writes, reads answered one to three cycles later

module tcdm_mem_model
  import tcdm_fifo_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        hold_gnt_i,    // keeps the grant low
  input  int unsigned gnt_pct_i,     // grant chance per cycle, percent
  input  logic        mem_req_i,
  input  addr_t       mem_addr_i,
  input  data_t       mem_wdata_i,
  input  be_t         mem_be_i,
  input  logic        mem_wen_i,     // high for a read
  output logic        mem_gnt_o,
  output logic        mem_r_valid_o,
  output data_t       mem_r_data_o,
  input  logic        mem_r_ready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  data_t       mem_q [addr_t];   // sparse, untouched words read the fill pattern
  data_t       rd_data_q [$];    // granted reads waiting for their answer
  int unsigned rd_due_q [$];     // cycle from which each answer may go out
  int unsigned cyc;
  logic        gnt_en;
  data_t       wr_word;

  assign mem_gnt_o = gnt_en & mem_req_i & ~hold_gnt_i; // only grants a pending request

  // every bit of the address takes part
  function automatic data_t fill_word(addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h6b1d_93c5;
  endfunction

  function automatic data_t read_word(addr_t a);
    return mem_q.exists(a) ? mem_q[a] : fill_word(a);
  endfunction

  initial begin
    gnt_en        = 1'b0;
    mem_r_valid_o = 1'b0;
    mem_r_data_o  = '0;
    cyc           = 0;
  end

  // handshakes taken mid-cycle where every signal has settled
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      rd_data_q.delete();
      rd_due_q.delete();
    end else if (mem_req_i && mem_gnt_o) begin
      if (mem_wen_i) begin
        rd_data_q.push_back(read_word(mem_addr_i));
        rd_due_q.push_back(cyc + $urandom_range(1, 3));
      end else begin
        wr_word = read_word(mem_addr_i);
        for (int i = 0; i < BE_W; i++) begin
          if (mem_be_i[i]) wr_word[8*i +: 8] = mem_wdata_i[8*i +: 8];
        end
        mem_q[mem_addr_i] = wr_word;
      end
    end
  end

  // outputs change shortly after the edge
  always @(posedge clk_i) begin
    cyc = cyc + 1;
    #2;
    gnt_en = ($urandom_range(99) < gnt_pct_i);
    // ready is a flop output, stable all cycle, so a raised valid always transfers
    if (rst_ni && rd_data_q.size() != 0 && rd_due_q[0] <= cyc && mem_r_ready_i) begin
      mem_r_valid_o = 1'b1;
      mem_r_data_o  = rd_data_q.pop_front();
      void'(rd_due_q.pop_front());
    end else begin
      mem_r_valid_o = 1'b0;
    end
  end

endmodule

/* tb/tb_tcdm_fifo.sv */
// testbench for the TCDM decoupling FIFO
// random core traffic, reference memory with expected queues, five tests

module tb_tcdm_fifo
  import tcdm_fifo_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SEED            = 32'h1f4e_8a48;
  localparam int          N_TESTS         = 5;
  localparam int          TEST_CYCLES_MAX = 1000;
  localparam int          TIMEOUT_CYCLES  = (N_TESTS + 1) * TEST_CYCLES_MAX; // margin of one test
  localparam addr_t       ADDR_BASE       = 32'h1000_0000;
  localparam int unsigned WINDOW_WORDS    = 16; // small window, frequent address reuse

  logic  clk_i, rst_ni, clear_i;
  logic  req_i, wen_i, gnt_o, r_valid_o, r_ready_i, empty_o;
  addr_t addr_i, mem_addr_o;
  data_t wdata_i, r_data_o, mem_wdata_o, mem_r_data_i;
  be_t   be_i, mem_be_o;
  logic  mem_req_o, mem_wen_o, mem_gnt_i, mem_r_valid_i, mem_r_ready_o;

  logic        hold_gnt;
  int unsigned gnt_pct, ready_pct;
  int          n_checks, n_errors;
  int          req_cnt, rsp_cnt;     // entries in request FIFO and response FIFO
  addr_t       exp_addr_q [$];       // accepted requests not yet seen at the memory
  data_t       exp_wdata_q [$];
  be_t         exp_be_q [$];
  logic        exp_wen_q [$];
  data_t       exp_rd_q [$];         // read data in issue order
  data_t       ref_mem [addr_t];

  tcdm_fifo DUT (.*);

  tcdm_mem_model i_mem (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .hold_gnt_i    ( hold_gnt      ),
    .gnt_pct_i     ( gnt_pct       ),
    .mem_req_i     ( mem_req_o     ),
    .mem_addr_i    ( mem_addr_o    ),
    .mem_wdata_i   ( mem_wdata_o   ),
    .mem_be_i      ( mem_be_o      ),
    .mem_wen_i     ( mem_wen_o     ),
    .mem_gnt_o     ( mem_gnt_i     ),
    .mem_r_valid_o ( mem_r_valid_i ),
    .mem_r_data_o  ( mem_r_data_i  ),
    .mem_r_ready_i ( mem_r_ready_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  // core side drains responses at a random rate
  initial begin
    r_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #2 r_ready_i = ($urandom_range(99) < ready_pct);
    end
  end

  task automatic check_data(input string name, input data_t exp, input data_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_be(input string name, input be_t exp, input be_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("[FAIL] %0t ns %s: expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("[FAIL] %0t ns %s: expected %b, got %b", $time, name, exp, act);
    end
  endtask

  // same preload as the memory model
  function automatic data_t initial_word(addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h6b1d_93c5;
  endfunction

  function automatic data_t ref_read(addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : initial_word(a);
  endfunction

  function automatic void ref_write(addr_t a, data_t d, be_t be);
    data_t w;
    w = ref_read(a);
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) w[8*i +: 8] = d[8*i +: 8];
    end
    ref_mem[a] = w;
  endfunction

  task automatic accept_request();
    exp_addr_q.push_back(addr_i);
    exp_wdata_q.push_back(wdata_i);
    exp_be_q.push_back(be_i);
    exp_wen_q.push_back(wen_i);
    if (wen_i) exp_rd_q.push_back(ref_read(addr_i)); // read sees all earlier writes
    else ref_write(addr_i, wdata_i, be_i);
    req_cnt++;
  endtask

  task automatic compare_issued();
    if (exp_addr_q.size() == 0) begin
      n_errors++;
      $display("error at %0t ns: memory side request with nothing accepted", $time);
    end else begin
      check_addr("mem_addr_o", exp_addr_q.pop_front(), mem_addr_o);
      check_data("mem_wdata_o", exp_wdata_q.pop_front(), mem_wdata_o);
      check_be("mem_be_o", exp_be_q.pop_front(), mem_be_o);
      check_bit("mem_wen_o", exp_wen_q.pop_front(), mem_wen_o);
    end
    req_cnt--;
  endtask

  task automatic compare_response();
    if (exp_rd_q.size() == 0) begin
      n_errors++;
      $display("error at %0t ns: response delivered with no read outstanding", $time);
    end else begin
      check_data("r_data_o", exp_rd_q.pop_front(), r_data_o);
    end
    rsp_cnt--;
  endtask

  // mid-cycle monitor; flags follow from the occupancy counts
  always @(negedge clk_i) begin
    int   arriving;
    logic room;
    if (rst_ni) begin
      arriving = (mem_r_valid_i && !r_ready_i) ? 1 : 0; // answer that would stay queued
      room     = (rsp_cnt + arriving < FIFO_DEPTH);
      check_bit("gnt_o", req_cnt < FIFO_DEPTH, gnt_o);
      check_bit("mem_req_o", req_cnt != 0 && room, mem_req_o);
      check_bit("mem_r_ready_o", rsp_cnt < FIFO_DEPTH, mem_r_ready_o);
      check_bit("r_valid_o", rsp_cnt != 0, r_valid_o);
      check_bit("empty_o", req_cnt == 0 && rsp_cnt == 0, empty_o);
      if (clear_i) begin
        req_cnt = 0;
        rsp_cnt = 0;
        exp_addr_q.delete();
        exp_wdata_q.delete();
        exp_be_q.delete();
        exp_wen_q.delete();
        exp_rd_q.delete();
      end else begin
        if (req_i && gnt_o) accept_request();
        if (mem_req_o && mem_gnt_i) compare_issued();
        if (mem_r_valid_i && mem_r_ready_o) rsp_cnt++;
        if (r_valid_o && r_ready_i) compare_response();
      end
    end
  end

  task automatic drive_random(input int unsigned rd_pct);
    req_i   = 1'b1;
    addr_i  = ADDR_BASE | addr_t'($urandom_range(WINDOW_WORDS - 1) << 2);
    wdata_i = data_t'($urandom);
    be_i    = be_t'($urandom_range(1, (1 << BE_W) - 1)); // at least one lane
    wen_i   = ($urandom_range(99) < rd_pct);
  endtask

  task automatic send_requests(input int n, input int unsigned rd_pct,
                               input int unsigned idle_pct);
    int sent;
    sent = 0;
    while (sent < n) begin
      @(posedge clk_i);
      #2;
      if ($urandom_range(99) < idle_pct) req_i = 1'b0;
      else drive_random(rd_pct);
      @(negedge clk_i);
      if (req_i && gnt_o) sent++;
    end
    @(posedge clk_i);
    #2 req_i = 1'b0;
  endtask

  // wait until every request went out and every read came back
  task automatic wait_drained();
    ready_pct = 100;
    do begin
      @(negedge clk_i);
      #1;
    end while (!(req_cnt == 0 && exp_rd_q.size() == 0));
    @(negedge clk_i); // last transfers land on the edge before this
    check_bit("empty_o", 1'b1, empty_o);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s finished, %0d errors", name, n_errors - errs_before);
  endtask

  initial begin
    int err0;
    int acc0;
    int granted;
    void'($urandom(SEED));
    rst_ni = 1'b0;
    clear_i = 1'b0;
    req_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    be_i = '0;
    wen_i = 1'b0;
    hold_gnt = 1'b0;
    gnt_pct = 70;
    ready_pct = 100;
    repeat (10) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    @(negedge clk_i);
    err0 = n_errors;
    check_bit("empty_o", 1'b1, empty_o);
    check_bit("gnt_o", 1'b1, gnt_o);
    check_bit("mem_req_o", 1'b0, mem_req_o);
    check_bit("r_valid_o", 1'b0, r_valid_o);
    err0 = n_errors - err0; // reset state belongs to the last test
    acc0 = n_errors;
    ready_pct = 80;
    send_requests(200, 50, 20);
    wait_drained();
    report_test("random reads and writes", acc0);
    acc0 = n_errors;
    gnt_pct = 100;
    send_requests(64, 50, 0); // back to back
    wait_drained();
    report_test("request order and fields", acc0);
    acc0 = n_errors;
    @(posedge clk_i);
    #2 hold_gnt = 1'b1;
    granted = 0;
    repeat (3 * FIFO_DEPTH) begin
      @(posedge clk_i);
      #2 drive_random(50);
      @(negedge clk_i);
      if (gnt_o) granted++;
    end
    if (granted > FIFO_DEPTH) begin
      n_errors++;
      $display("error: %0d requests granted while memory held grant low", granted);
    end
    @(posedge clk_i);
    #2 req_i = 1'b0;
    repeat (5) begin
      @(negedge clk_i);
      check_bit("gnt_o", 1'b0, gnt_o); // full until memory grants again
    end
    @(posedge clk_i);
    #2 hold_gnt = 1'b0;
    gnt_pct = 70;
    wait_drained();
    report_test("request back-pressure", acc0);
    acc0 = n_errors;
    gnt_pct = 80;
    ready_pct = 25; // responses pile up in the queue
    send_requests(120, 80, 10);
    wait_drained();
    report_test("response back-pressure", acc0);
    acc0 = n_errors - err0;
    @(posedge clk_i);
    #2 hold_gnt = 1'b1;
    send_requests(5, 100, 0); // reads only, so the reference memory stays valid
    @(posedge clk_i);
    #2 clear_i = 1'b1;
    @(posedge clk_i);
    #2 clear_i = 1'b0;
    @(negedge clk_i);
    check_bit("empty_o", 1'b1, empty_o);
    check_bit("mem_req_o", 1'b0, mem_req_o);
    @(posedge clk_i);
    #2 hold_gnt = 1'b0;
    ready_pct = 70;
    send_requests(40, 50, 20);
    wait_drained();
    report_test("reset, drain and clear", acc0);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
verilog/tcdm_fifo_pkg.sv
verilog/sync_fifo.sv
verilog/req_queue.sv
verilog/resp_queue.sv
verilog/tcdm_fifo.sv
tb/tcdm_mem_model.sv
tb/tb_tcdm_fifo.sv
